// File: src/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and instruction width.
`define CPU_WIDTH 16

// architectural registers, r0 reads as zero.
`define CPU_REGS 16

// word-addressed memories.
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// fetch packets held between fetch and execute, power of two.
`define CPU_QUEUE_DEPTH 4

`endif

// File: src/isaPkg.sv
`default_nettype none
`include "cpu_defines.svh"

package isaPkg;

  typedef logic [`CPU_WIDTH-1:0] word_t;
  typedef logic [$clog2(`CPU_REGS)-1:0] regIdx_t;
  typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0] addr_t;

  typedef logic [7:0] imm8_t;  // LHB, LLB and branch offset.
  typedef logic [3:0] imm4_t;  // shift amount and load/store offset.

  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_NOR  = 4'd3,
    OP_SLL  = 4'd4,
    OP_SRL  = 4'd5,
    OP_LW   = 4'd8,
    OP_SW   = 4'd9,
    OP_LHB  = 4'd10,
    OP_LLB  = 4'd11,
    OP_BEQZ = 4'd12,
    OP_JAL  = 4'd13,
    OP_JR   = 4'd14,
    OP_HLT  = 4'd15
  } opcode_t;

endpackage

`default_nettype wire

// File: src/pipePkg.sv
`default_nettype none

package pipePkg;

  import isaPkg::*;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetchPacket_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

  // write-back trace.
  typedef struct packed {
    logic    valid;
    regIdx_t idx;
    word_t   data;
  } regWrite_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    word_t instr;
  } progWrite_t;

  typedef enum logic [1:0] {EMPTY, PARTIAL, FULL} queueState_t;

endpackage

`default_nettype wire

// File: src/fetchUnit.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defines.svh"

module fetchUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  pipePkg::progWrite_t   prog,
  input  pipePkg::redirect_t    redirect,
  output logic                  outValid,
  input  logic                  outReady,
  output pipePkg::fetchPacket_t outPacket
);

  import isaPkg::*;

  word_t imem [`CPU_IMEM_DEPTH];
  word_t pcReg;   // next address to fetch.
  addr_t fetchAddr;
  logic  advance;

  assign fetchAddr = pcReg[$bits(addr_t)-1:0];
  assign advance   = !outValid || outReady;  // slot free or being taken.

  // **************************************************
  // program load, only while the core is in reset
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst && prog.en) begin
      imem[prog.addr] <= prog.instr;
    end
  end

  // **************************************************
  // pc and output holding register
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      pcReg    <= '0;
      outValid <= 1'b0;
    end else if (redirect.valid) begin
      pcReg    <= redirect.target;  // held packet is dropped.
      outValid <= 1'b0;
    end else if (advance) begin
      outValid  <= 1'b1;
      outPacket <= '{pc: pcReg, instr: imem[fetchAddr]};
      pcReg     <= pcReg + 1'b1;
    end
  end

  // a stalled packet must not change under the queue.
  assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady && !redirect.valid) |=> (outValid && $stable(outPacket)));

endmodule

`default_nettype wire

// File: src/instrQueue.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defines.svh"

module instrQueue (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  flush,
  input  logic                  inValid,
  output logic                  inReady,
  input  pipePkg::fetchPacket_t inPacket,
  output logic                  outValid,
  input  logic                  outReady,
  output pipePkg::fetchPacket_t outPacket
);

  import pipePkg::*;

  localparam int PTR_W = $clog2(`CPU_QUEUE_DEPTH);

  fetchPacket_t buffer [`CPU_QUEUE_DEPTH];
  logic [PTR_W-1:0] rdPtr, wrPtr, rdNext, wrNext;  // wrap needs power-of-two depth.
  queueState_t state;
  logic push, pop;

  assign inReady   = (state != FULL);
  assign outValid  = (state != EMPTY);
  assign outPacket = buffer[rdPtr];

  assign push   = inValid && inReady && !flush;  // flush drops the incoming packet.
  assign pop    = outValid && outReady;
  assign rdNext = rdPtr + 1'b1;
  assign wrNext = wrPtr + 1'b1;

  always_ff @(posedge clk) begin
    if (push) begin
      buffer[wrPtr] <= inPacket;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      rdPtr <= '0;
      wrPtr <= '0;
      state <= EMPTY;
    end else begin
      if (push) wrPtr <= wrNext;
      if (pop) rdPtr <= rdNext;
      case ({push, pop})
        2'b10:   state <= (wrNext == rdPtr) ? FULL : PARTIAL;
        2'b01:   state <= (rdNext == wrPtr) ? EMPTY : PARTIAL;
        default: state <= state;  // idle, or push and pop together.
      endcase
    end
  end

  // full never takes a packet, empty never gives one.
  assert property (@(posedge clk) disable iff (rst)
    (state == FULL && !flush) |=> $stable(wrPtr));
  assert property (@(posedge clk) disable iff (rst)
    (state == EMPTY && !flush) |=> $stable(rdPtr));

endmodule

`default_nettype wire

// File: src/executeCore.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defines.svh"

module executeCore (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inValid,
  output logic                  inReady,
  input  pipePkg::fetchPacket_t inPacket,
  output pipePkg::redirect_t    redirect,
  output pipePkg::regWrite_t    trace,
  output logic                  hlt,
  output isaPkg::word_t         pc
);

  import isaPkg::*;
  import pipePkg::*;

  word_t regs [`CPU_REGS];
  word_t dmem [`CPU_DMEM_DEPTH];

  opcode_t op;
  regIdx_t rdIdx, rsIdx, rtIdx, destIdx;
  imm8_t   imm8;
  imm4_t   imm4;
  word_t   rdVal, rsVal, rtVal;
  word_t   pcNext, branchTarget, jumpTarget, memAddrWord, wbData;
  addr_t   memAddr;
  logic    fire, regWe, taken;

  // **************************************************
  // decode and operand read
  // **************************************************
  assign op    = opcode_t'(inPacket.instr[15:12]);
  assign rdIdx = inPacket.instr[11:8];
  assign rsIdx = inPacket.instr[7:4];
  assign rtIdx = inPacket.instr[3:0];
  assign imm8  = inPacket.instr[7:0];
  assign imm4  = inPacket.instr[3:0];  // shares bits with rt.

  assign rdVal = (rdIdx == '0) ? '0 : regs[rdIdx];
  assign rsVal = (rsIdx == '0) ? '0 : regs[rsIdx];
  assign rtVal = (rtIdx == '0) ? '0 : regs[rtIdx];

  assign pcNext       = inPacket.pc + 1'b1;
  assign branchTarget = pcNext + {{(`CPU_WIDTH-8){imm8[7]}}, imm8};
  assign memAddrWord  = rsVal + {{(`CPU_WIDTH-4){imm4[3]}}, imm4};
  assign memAddr      = memAddrWord[$bits(addr_t)-1:0];

  assign inReady = !hlt;  // nothing more once halted.
  assign fire    = inValid && inReady;

  // **************************************************
  // execute
  // **************************************************
  always_comb begin
    regWe      = 1'b1;
    destIdx    = rdIdx;
    wbData     = '0;
    taken      = 1'b0;
    jumpTarget = branchTarget;
    case (op)
      OP_ADD:  wbData = rsVal + rtVal;
      OP_SUB:  wbData = rsVal - rtVal;
      OP_AND:  wbData = rsVal & rtVal;
      OP_NOR:  wbData = ~(rsVal | rtVal);
      OP_SLL:  wbData = rsVal << imm4;
      OP_SRL:  wbData = rsVal >> imm4;
      OP_LW:   wbData = dmem[memAddr];
      OP_LHB:  wbData = {imm8, rdVal[7:0]};
      OP_LLB:  wbData = {{(`CPU_WIDTH-8){imm8[7]}}, imm8};
      OP_JAL: begin
        wbData  = pcNext;
        destIdx = regIdx_t'(`CPU_REGS - 1);  // link register.
        taken   = 1'b1;
      end
      OP_BEQZ: begin
        regWe = 1'b0;
        taken = (rdVal == '0);
      end
      OP_JR: begin
        regWe      = 1'b0;
        taken      = 1'b1;
        jumpTarget = rsVal;
      end
      default: regWe = 1'b0;  // SW, HLT and unused codes.
    endcase
  end

  assign redirect = '{valid: fire && taken, target: jumpTarget};

  // **************************************************
  // register file, data memory, state
  // **************************************************
  always_ff @(posedge clk) begin
    if (fire && regWe && destIdx != '0) begin
      regs[destIdx] <= wbData;
    end
  end

  always_ff @(posedge clk) begin
    if (fire && op == OP_SW) begin
      dmem[memAddr] <= rdVal;
    end
  end

  always_ff @(posedge clk) begin
    trace.idx  <= destIdx;
    trace.data <= wbData;
    if (rst) begin
      trace.valid <= 1'b0;
    end else begin
      trace.valid <= fire && regWe && (destIdx != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hlt <= 1'b0;
      pc  <= '0;
    end else if (fire) begin
      pc <= inPacket.pc;
      if (op == OP_HLT) hlt <= 1'b1;
    end
  end

  // halted core stays quiet and keeps its pc.
  assert property (@(posedge clk) disable iff (rst)
    hlt |=> (!redirect.valid && !trace.valid && $stable(pc)));

endmodule

`default_nettype wire

// File: src/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop (
  input  logic                clk,
  input  logic                rst,
  input  pipePkg::progWrite_t prog,
  output pipePkg::regWrite_t  trace,
  output logic                hlt,
  output isaPkg::word_t       pc
);

  import pipePkg::*;

  logic fetchValid, fetchReady, queueValid, queueReady;
  fetchPacket_t fetchPacket, queuePacket;
  redirect_t redirect;

  fetchUnit u_fetch (
    .clk(clk),
    .rst(rst),
    .prog(prog),
    .redirect(redirect),
    .outValid(fetchValid),
    .outReady(fetchReady),
    .outPacket(fetchPacket)
  );

  instrQueue u_queue (
    .clk(clk),
    .rst(rst),
    .flush(redirect.valid),  // taken branch empties the queue.
    .inValid(fetchValid),
    .inReady(fetchReady),
    .inPacket(fetchPacket),
    .outValid(queueValid),
    .outReady(queueReady),
    .outPacket(queuePacket)
  );

  executeCore u_exec (
    .clk(clk),
    .rst(rst),
    .inValid(queueValid),
    .inReady(queueReady),
    .inPacket(queuePacket),
    .redirect(redirect),
    .trace(trace),
    .hlt(hlt),
    .pc(pc)
  );

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // free running.
  end

endmodule

`default_nettype wire

// File: testbench/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTb;

  import isaPkg::*;
  import pipePkg::*;

  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int RESET_CYCLES    = 16;
  localparam int HALT_LIMIT      = 1000;

  logic       clk, rst, hlt;
  progWrite_t prog;
  regWrite_t  trace;
  word_t      pc;

  word_t     progWords[$];
  regWrite_t expTrace[$];
  regWrite_t gotTrace[$];
  int        errors   = 0;
  int        testsRun = 0;

  tbClock #(.PERIOD_NS(100)) u_clock (.clk(clk));

  cpuTop u_dut (
    .clk(clk),
    .rst(rst),
    .prog(prog),
    .trace(trace),
    .hlt(hlt),
    .pc(pc)
  );

  initial begin
    repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
    $display("watchdog expired at %0t, the run did not finish", $time);
    $display("Checks failed");
    $finish;
  end

  // **************************************************
  // encoding and compare helpers
  // **************************************************
  function automatic word_t encR(opcode_t op, regIdx_t rd, regIdx_t rs, regIdx_t rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic word_t encI(opcode_t op, regIdx_t rd, imm8_t imm);
    return {op, rd, imm};
  endfunction

  task automatic checkWrite(input regWrite_t got, input regWrite_t exp, input string msg);
    if (got.idx !== exp.idx || got.data !== exp.data) begin
      errors++;
      $display("Fail %0t: %s got r%0d=%h expected r%0d=%h",
               $time, msg, got.idx, got.data, exp.idx, exp.data);
    end
  endtask

  task automatic checkWord(input word_t got, input word_t exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  // **************************************************
  // program setup and run control
  // **************************************************
  task automatic startTest();
    progWords.delete();
    expTrace.delete();
    gotTrace.delete();
    testsRun++;
  endtask

  task automatic addExpect(input regIdx_t idx, input word_t data);
    expTrace.push_back('{valid: 1'b1, idx: idx, data: data});
  endtask

  task automatic addTraced(input word_t instr, input regIdx_t idx, input word_t data);
    progWords.push_back(instr);
    addExpect(idx, data);
  endtask

  task automatic addSilent(input word_t instr);
    progWords.push_back(instr);
  endtask

  // loads one program word per reset cycle and leaves reset high.
  task automatic loadAndReset();
    int cycles;
    cycles = (progWords.size() > RESET_CYCLES) ? progWords.size() : RESET_CYCLES;
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < cycles; i++) begin
      if (i < progWords.size()) prog <= '{en: 1'b1, addr: addr_t'(i), instr: progWords[i]};
      else prog <= '0;
      @(posedge clk);
    end
    prog <= '0;
  endtask

  task automatic runUntilHalt();
    int cycles;
    cycles = 0;
    while (hlt !== 1'b1 && cycles < HALT_LIMIT) begin
      @(negedge clk);
      if (trace.valid) gotTrace.push_back(trace);
      cycles++;
    end
    if (hlt !== 1'b1) begin
      errors++;
      $display("no halt within %0d cycles at %0t", HALT_LIMIT, $time);
    end
  endtask

  task automatic compareTrace(input string name);
    int n;
    n = (gotTrace.size() < expTrace.size()) ? gotTrace.size() : expTrace.size();
    for (int i = 0; i < n; i++) begin
      checkWrite(gotTrace[i], expTrace[i], $sformatf("%s trace entry %0d", name, i));
    end
    if (gotTrace.size() < expTrace.size()) begin
      errors++;
      $display("%s is missing %0d trace entries", name, expTrace.size() - gotTrace.size());
    end else if (gotTrace.size() > expTrace.size()) begin
      errors++;
      $display("%s has %0d extra trace entries", name, gotTrace.size() - expTrace.size());
    end
  endtask

  task automatic runProgram(input string name, input word_t hltPc);
    rst <= 1'b0;
    runUntilHalt();
    compareTrace(name);
    checkWord(pc, hltPc, {name, " halt pc"});
  endtask

  // **************************************************
  // directed tests
  // **************************************************
  task automatic testReset();
    startTest();
    addTraced(encI(OP_LLB, 4'd1, 8'h5A), 4'd1, 16'h005A);
    addSilent(encI(OP_HLT, 4'd0, 8'h00));
    loadAndReset();
    repeat (2) begin
      @(negedge clk);
      checkFlag(hlt, 1'b0, "hlt in reset");
      checkFlag(trace.valid, 1'b0, "trace valid in reset");
      checkWord(pc, 16'h0000, "pc in reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(negedge clk);  // past the first edge that sees rst low.
    checkFlag(hlt, 1'b0, "hlt after reset");
    checkFlag(trace.valid, 1'b0, "trace valid after reset");
    checkWord(pc, 16'h0000, "pc after reset");
    runUntilHalt();
    compareTrace("reset");
    checkWord(pc, 16'd1, "reset halt pc");
  endtask

  task automatic testArith();
    startTest();
    addTraced(encI(OP_LLB, 4'd1, 8'h34), 4'd1, 16'h0034);
    addTraced(encI(OP_LHB, 4'd1, 8'h12), 4'd1, 16'h1234);  // low byte kept.
    addTraced(encI(OP_LLB, 4'd2, 8'hF0), 4'd2, 16'hFFF0);
    addTraced(encR(OP_ADD, 4'd3, 4'd1, 4'd2), 4'd3, 16'h1224);
    addTraced(encR(OP_SUB, 4'd4, 4'd1, 4'd2), 4'd4, 16'h1244);
    addTraced(encR(OP_AND, 4'd5, 4'd1, 4'd2), 4'd5, 16'h1230);
    addTraced(encR(OP_NOR, 4'd6, 4'd1, 4'd2), 4'd6, 16'h000B);
    addTraced(encR(OP_SLL, 4'd7, 4'd1, 4'd4), 4'd7, 16'h2340);
    addTraced(encR(OP_SRL, 4'd8, 4'd1, 4'd4), 4'd8, 16'h0123);
    addSilent(encR(OP_ADD, 4'd0, 4'd1, 4'd1));  // r0 stays zero.
    addTraced(encR(OP_ADD, 4'd9, 4'd0, 4'd1), 4'd9, 16'h1234);
    addSilent(encI(OP_HLT, 4'd0, 8'h00));
    loadAndReset();
    runProgram("arith", 16'd11);
  endtask

  task automatic testMemory();
    startTest();
    addTraced(encI(OP_LLB, 4'd1, 8'h10), 4'd1, 16'h0010);
    addTraced(encI(OP_LLB, 4'd2, 8'h55), 4'd2, 16'h0055);
    addTraced(encI(OP_LLB, 4'd3, 8'hAA), 4'd3, 16'hFFAA);
    addTraced(encI(OP_LLB, 4'd4, 8'h7E), 4'd4, 16'h007E);
    addSilent(encR(OP_SW, 4'd2, 4'd1, 4'h0));  // mem[0x10].
    addSilent(encR(OP_SW, 4'd3, 4'd1, 4'h1));  // mem[0x11].
    addSilent(encR(OP_SW, 4'd4, 4'd1, 4'hF));  // mem[0x0F].
    addTraced(encR(OP_LW, 4'd5, 4'd1, 4'hF), 4'd5, 16'h007E);
    addTraced(encR(OP_LW, 4'd6, 4'd1, 4'h1), 4'd6, 16'hFFAA);
    addTraced(encR(OP_LW, 4'd7, 4'd1, 4'h0), 4'd7, 16'h0055);
    addSilent(encI(OP_HLT, 4'd0, 8'h00));
    loadAndReset();
    runProgram("memory", 16'd10);
  endtask

  task automatic testControl();
    startTest();
    addSilent(encI(OP_LLB, 4'd1, 8'h00));
    addSilent(encI(OP_LLB, 4'd2, 8'h05));
    addSilent(encI(OP_BEQZ, 4'd1, 8'h02));   // taken, to 5.
    addSilent(encI(OP_LLB, 4'd10, 8'hEE));
    addSilent(encI(OP_LLB, 4'd11, 8'hEE));
    addSilent(encI(OP_BEQZ, 4'd2, 8'h01));   // not taken.
    addSilent(encI(OP_LLB, 4'd3, 8'h33));
    addSilent(encI(OP_JAL, 4'd0, 8'h03));    // to 11, link 8.
    addSilent(encI(OP_LLB, 4'd4, 8'h44));
    addSilent(encI(OP_HLT, 4'd0, 8'h00));
    addSilent(encI(OP_LLB, 4'd12, 8'hEE));
    addSilent(encI(OP_LLB, 4'd5, 8'h55));
    addSilent(encR(OP_JR, 4'd0, 4'd15, 4'd0));
    addSilent(encI(OP_LLB, 4'd13, 8'hEE));
    // execution order 0 1 2 5 6 7 11 12 8 9.
    addExpect(4'd1, 16'h0000);
    addExpect(4'd2, 16'h0005);
    addExpect(4'd3, 16'h0033);
    addExpect(4'd15, 16'h0008);
    addExpect(4'd5, 16'h0055);
    addExpect(4'd4, 16'h0044);
    loadAndReset();
    runProgram("control", 16'd9);
    foreach (gotTrace[i]) begin
      if (gotTrace[i].idx >= 4'd10 && gotTrace[i].idx <= 4'd13) begin
        errors++;
        $display("a skipped marker instruction wrote r%0d", gotTrace[i].idx);
      end
    end
  endtask

  task automatic testHalt();
    startTest();
    addTraced(encI(OP_LLB, 4'd1, 8'h01), 4'd1, 16'h0001);
    addTraced(encI(OP_LLB, 4'd2, 8'h02), 4'd2, 16'h0002);
    addSilent(encI(OP_HLT, 4'd0, 8'h00));
    addSilent(encI(OP_LLB, 4'd3, 8'h03));
    addSilent(encR(OP_ADD, 4'd4, 4'd1, 4'd2));
    addSilent(encI(OP_LLB, 4'd5, 8'h05));
    loadAndReset();
    runProgram("halt", 16'd2);
    repeat (50) begin
      @(negedge clk);
      checkFlag(hlt, 1'b1, "hlt after halt");
      if (trace.valid) begin
        errors++;
        $display("trace entry for r%0d after halt at %0t", trace.idx, $time);
      end
    end
    checkWord(pc, 16'd2, "pc long after halt");
  endtask

  initial begin
    rst  <= 1'b1;
    prog <= '0;
    testReset();
    testArith();
    testMemory();
    testControl();
    testHalt();
    $display("tests run: %0d, errors: %0d", testsRun, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/fetchUnit.sv
src/instrQueue.sv
src/executeCore.sv
src/cpuTop.sv
testbench/tbClock.sv
testbench/cpuTb.sv

// File: run.sh
#!/bin/sh
# build and run the cpu testbench with verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cpuTb -f sim.f --Mdir "$BUILD" -o cpuSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BUILD"/cpuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  exit 1
fi
exit 0
